//--- rtl/isa_pkg.sv
package isa_pkg;

  // Datapath and register file
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  // Major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  // funct3 values
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_beq = 3'b000;

  localparam logic [6:0] f7_sub = 7'b0100000;  // Marks sub among op_reg

  // Kind of work handed from execute to the load/store unit
  localparam int         kind_w     = 2;
  localparam logic [1:0] kind_alu   = 2'd0;
  localparam logic [1:0] kind_load  = 2'd1;
  localparam logic [1:0] kind_store = 2'd2;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Store and branch layout, immediate split around the register fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    s_fmt_t s_fmt;
  } instr_t;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

  // Bus byte address
  localparam int addr_w = 32;

  // TCM geometry, one 32-bit word per entry
  localparam int mem_words = 256;
  localparam int index_w   = 8;

  // First fetch address out of reset
  localparam logic [addr_w-1:0] reset_pc = '0;

endpackage

//--- rtl/tcm.sv
`timescale 1ns/1ps

module tcm (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [mem_pkg::addr_w-1:0]  cpu_addr,
  input  logic                        cpu_rd,
  input  logic                        cpu_wr,
  input  logic [isa_pkg::xlen-1:0]    cpu_wr_data,
  output logic [isa_pkg::xlen-1:0]    cpu_rd_data,
  output logic                        cpu_waitrequest,
  input  logic                        load_en,
  input  logic [mem_pkg::index_w-1:0] load_addr,
  input  logic [isa_pkg::xlen-1:0]    load_data
);

  logic [isa_pkg::xlen-1:0]    mem [mem_pkg::mem_words];
  logic [mem_pkg::index_w-1:0] index;
  logic                        waited;  // Wait state already spent

  assign index = cpu_addr[mem_pkg::index_w+1:2];  // Word select from byte address

  // One wait state at the start of every request
  assign cpu_waitrequest = (cpu_rd || cpu_wr) && !waited;

  always_ff @(posedge clock) begin
    if (reset) begin
      waited <= 1'b0;
    end else begin
      waited <= (cpu_rd || cpu_wr) && !waited;
    end
  end

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // Program load
    end else if (cpu_wr && !cpu_waitrequest) begin
      mem[index] <= cpu_wr_data;
    end
    cpu_rd_data <= mem[index];  // Ready by the completing cycle
  end

  a_rd_wr_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(cpu_rd && cpu_wr)
  ) else $error("tcm: rd and wr high together");

  // Master must hold the request through the wait state
  a_addr_stable: assert property (
    @(posedge clock) disable iff (reset)
    cpu_waitrequest |=> (cpu_rd || cpu_wr) && $stable(cpu_addr)
  ) else $error("tcm: request dropped or address moved during waitrequest");

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clock,
  input  logic                       reset,
  output logic [mem_pkg::addr_w-1:0] icache_addr,
  output logic                       icache_rd,
  input  logic [isa_pkg::xlen-1:0]   icache_data,
  input  logic                       icache_waitrequest,
  output logic                       instr_valid,
  output logic [isa_pkg::xlen-1:0]   instr,
  output logic [mem_pkg::addr_w-1:0] instr_pc,
  input  logic                       instr_taken,
  input  logic                       redirect,
  input  logic [mem_pkg::addr_w-1:0] redirect_pc
);

  logic [mem_pkg::addr_w-1:0] fetch_pc;  // Next address to request
  logic [mem_pkg::addr_w-1:0] pc_sel;
  logic                       drop;      // Read in flight is stale
  logic                       done;
  logic                       buf_next;
  logic                       issue;

  assign done   = icache_rd && !icache_waitrequest;
  assign pc_sel = redirect ? redirect_pc : fetch_pc;

  always_comb begin
    if (redirect) begin
      buf_next = 1'b0;
    end else if (done && !drop) begin
      buf_next = 1'b1;
    end else if (instr_valid && instr_taken) begin
      buf_next = 1'b0;
    end else begin
      buf_next = instr_valid;
    end
    // Only request when the word has a free slot to land in
    issue = (!icache_rd || done) && !buf_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      icache_rd   <= 1'b0;
      instr_valid <= 1'b0;
      drop        <= 1'b0;
      fetch_pc    <= mem_pkg::reset_pc;
    end else begin
      icache_rd   <= (icache_rd && !done) || issue;
      instr_valid <= buf_next;
      if (redirect && icache_rd && !done) begin
        drop <= 1'b1;  // Let the bus finish, discard the word
      end else if (done) begin
        drop <= 1'b0;
      end
      if (issue) begin
        fetch_pc <= pc_sel + 4;
      end else if (redirect) begin
        fetch_pc <= redirect_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      icache_addr <= pc_sel;
    end
    if (done && !drop) begin
      instr    <= icache_data;
      instr_pc <= icache_addr;
    end
  end

  // No read may complete on top of a word that is still waiting
  a_buf_held: assert property (
    @(posedge clock) disable iff (reset)
    instr_valid && !instr_taken && !redirect |=>
      instr_valid && $stable(instr) && $stable(instr_pc)
  ) else $error("fetch_unit: buffered instruction changed before it was taken");

endmodule

//--- rtl/rfile.sv
`timescale 1ns/1ps

module rfile (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [isa_pkg::reg_addr_w-1:0] rd_addr1,
  input  logic [isa_pkg::reg_addr_w-1:0] rd_addr2,
  input  logic [isa_pkg::reg_addr_w-1:0] wr_addr1,
  input  logic                           wr_enable1,
  input  logic [isa_pkg::xlen-1:0]       wr_data1,
  output logic [isa_pkg::xlen-1:0]       rd_data1,
  output logic [isa_pkg::xlen-1:0]       rd_data2
);

  logic [isa_pkg::xlen-1:0] regs [isa_pkg::reg_count];

  // x0 reads as zero whatever the array holds
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < isa_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_enable1 && wr_addr1 != '0) begin
      regs[wr_addr1] <= wr_data1;
    end
  end

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           instr_valid,
  input  logic [isa_pkg::xlen-1:0]       instr,
  input  logic [mem_pkg::addr_w-1:0]     instr_pc,
  output logic                           instr_taken,
  output logic                           redirect,
  output logic [mem_pkg::addr_w-1:0]     redirect_pc,
  output logic [isa_pkg::reg_addr_w-1:0] rfile_rd_addr1,
  output logic [isa_pkg::reg_addr_w-1:0] rfile_rd_addr2,
  input  logic [isa_pkg::xlen-1:0]       rfile_rd_data1,
  input  logic [isa_pkg::xlen-1:0]       rfile_rd_data2,
  output logic                           op_valid,
  output logic [isa_pkg::kind_w-1:0]     op_kind,
  output logic [isa_pkg::reg_addr_w-1:0] op_rd,
  output logic [isa_pkg::xlen-1:0]       op_value,
  output logic [mem_pkg::addr_w-1:0]     op_addr,
  output logic [isa_pkg::xlen-1:0]       op_store_data,
  output logic [mem_pkg::addr_w-1:0]     op_pc,
  input  logic                           lsu_busy
);

  isa_pkg::instr_t          ir;
  logic [6:0]               opcode;
  logic [isa_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u;
  logic [isa_pkg::xlen-1:0] alu_b, alu_out, value;
  logic                     is_sub, beq_hit, writes_rd, take;

  assign ir     = instr;
  assign opcode = ir.r_fmt.opcode;

  assign rfile_rd_addr1 = ir.r_fmt.rs1;
  assign rfile_rd_addr2 = ir.r_fmt.rs2;

  // Immediates
  assign imm_i = {{20{ir.r_fmt.funct7[6]}}, ir.r_fmt.funct7, ir.r_fmt.rs2};
  assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
  assign imm_b = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_lo[0], ir.s_fmt.imm_hi[5:0],
                  ir.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {ir.r_fmt.funct7, ir.r_fmt.rs2, ir.r_fmt.rs1, ir.r_fmt.funct3, 12'b0};

  always_comb begin
    alu_b  = (opcode == isa_pkg::op_reg) ? rfile_rd_data2 : imm_i;
    is_sub = (opcode == isa_pkg::op_reg) && (ir.r_fmt.funct7 == isa_pkg::f7_sub);
    case (ir.r_fmt.funct3)
      isa_pkg::f3_add: alu_out = is_sub ? rfile_rd_data1 - alu_b : rfile_rd_data1 + alu_b;
      isa_pkg::f3_slt: alu_out = {{(isa_pkg::xlen-1){1'b0}},
                                  $signed(rfile_rd_data1) < $signed(alu_b)};
      isa_pkg::f3_xor: alu_out = rfile_rd_data1 ^ alu_b;
      isa_pkg::f3_or:  alu_out = rfile_rd_data1 | alu_b;
      isa_pkg::f3_and: alu_out = rfile_rd_data1 & alu_b;
      default:         alu_out = '0;
    endcase

    case (opcode)
      isa_pkg::op_reg, isa_pkg::op_imm: value = alu_out;
      isa_pkg::op_lui:                  value = imm_u;
      default:                          value = '0;  // Stores and branches carry no result
    endcase

    writes_rd = (opcode == isa_pkg::op_reg) || (opcode == isa_pkg::op_imm) ||
                (opcode == isa_pkg::op_lui) || (opcode == isa_pkg::op_load);
    beq_hit   = (opcode == isa_pkg::op_branch) && (ir.s_fmt.funct3 == isa_pkg::f3_beq) &&
                (rfile_rd_data1 == rfile_rd_data2);
  end

  // Operands are read only once the previous writeback has landed
  assign take        = instr_valid && !lsu_busy && !redirect;
  assign instr_taken = take;

  always_ff @(posedge clock) begin
    if (reset) begin
      op_valid <= 1'b0;
      redirect <= 1'b0;
    end else begin
      op_valid <= take;
      redirect <= take && beq_hit;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      op_pc         <= instr_pc;
      op_rd         <= writes_rd ? ir.r_fmt.rd : '0;
      op_value      <= value;
      op_store_data <= rfile_rd_data2;
      op_addr       <= rfile_rd_data1 + ((opcode == isa_pkg::op_store) ? imm_s : imm_i);
      redirect_pc   <= instr_pc + imm_b;
      if (opcode == isa_pkg::op_load) begin
        op_kind <= isa_pkg::kind_load;
      end else if (opcode == isa_pkg::op_store) begin
        op_kind <= isa_pkg::kind_store;
      end else begin
        op_kind <= isa_pkg::kind_alu;  // Branches retire through the ALU path
      end
    end
  end

  // Busy must cover the handoff and the writeback cycle after it
  a_busy_after_handoff: assert property (
    @(posedge clock) disable iff (reset) (op_valid || $past(op_valid)) |-> lsu_busy
  ) else $error("execute_unit: lsu not busy through handoff and writeback");

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           op_valid,
  input  logic [isa_pkg::kind_w-1:0]     op_kind,
  input  logic [isa_pkg::reg_addr_w-1:0] op_rd,
  input  logic [isa_pkg::xlen-1:0]       op_value,
  input  logic [mem_pkg::addr_w-1:0]     op_addr,
  input  logic [isa_pkg::xlen-1:0]       op_store_data,
  input  logic [mem_pkg::addr_w-1:0]     op_pc,
  output logic                           lsu_busy,
  output logic [mem_pkg::addr_w-1:0]     dcache_addr,
  output logic                           dcache_rd,
  output logic                           dcache_wr,
  output logic [isa_pkg::xlen-1:0]       dcache_wr_data,
  input  logic [isa_pkg::xlen-1:0]       dcache_data,
  input  logic                           dcache_waitrequest,
  output logic [isa_pkg::reg_addr_w-1:0] rfile_wr_addr1,
  output logic                           rfile_wr_enable1,
  output logic [isa_pkg::xlen-1:0]       rfile_wr_data1,
  output logic                           retire_valid,
  output logic [mem_pkg::addr_w-1:0]     retire_pc,
  output logic [isa_pkg::reg_addr_w-1:0] retire_rd,
  output logic [isa_pkg::xlen-1:0]       retire_data,
  output logic                           retire_wen
);

  logic                           access_q, retire_q;
  logic [isa_pkg::kind_w-1:0]     kind_q;
  logic [isa_pkg::reg_addr_w-1:0] rd_q;
  logic [isa_pkg::xlen-1:0]       result_q;  // ALU value, store word or load data
  logic [mem_pkg::addr_w-1:0]     addr_q, pc_q;
  logic                           access_done;

  assign access_done = access_q && !dcache_waitrequest;

  always_ff @(posedge clock) begin
    if (reset) begin
      access_q <= 1'b0;
      retire_q <= 1'b0;
    end else begin
      access_q <= op_valid ? (op_kind != isa_pkg::kind_alu) : (access_q && !access_done);
      retire_q <= (op_valid && op_kind == isa_pkg::kind_alu) || access_done;
    end
  end

  always_ff @(posedge clock) begin
    if (op_valid) begin
      kind_q   <= op_kind;
      rd_q     <= op_rd;
      addr_q   <= op_addr;
      pc_q     <= op_pc;
      result_q <= (op_kind == isa_pkg::kind_store) ? op_store_data : op_value;
    end else if (access_done && kind_q == isa_pkg::kind_load) begin
      result_q <= dcache_data;
    end
  end

  assign lsu_busy       = op_valid || access_q || retire_q;
  assign dcache_addr    = addr_q;
  assign dcache_rd      = access_q && (kind_q == isa_pkg::kind_load);
  assign dcache_wr      = access_q && (kind_q == isa_pkg::kind_store);
  assign dcache_wr_data = result_q;

  // rd_q is zero for stores and branches
  assign retire_wen       = retire_q && (rd_q != '0);
  assign retire_valid     = retire_q;
  assign retire_pc        = pc_q;
  assign retire_rd        = rd_q;
  assign retire_data      = result_q;
  assign rfile_wr_addr1   = rd_q;
  assign rfile_wr_enable1 = retire_wen;
  assign rfile_wr_data1   = result_q;

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           load_en,
  input  logic [mem_pkg::index_w-1:0]    load_addr,
  input  logic [isa_pkg::xlen-1:0]       load_data,
  output logic                           retire_valid,
  output logic [mem_pkg::addr_w-1:0]     retire_pc,
  output logic [isa_pkg::reg_addr_w-1:0] retire_rd,
  output logic [isa_pkg::xlen-1:0]       retire_data,
  output logic                           retire_wen
);

  logic [mem_pkg::addr_w-1:0]     icache_addr, dcache_addr, instr_pc, redirect_pc;
  logic [mem_pkg::addr_w-1:0]     op_addr, op_pc;
  logic                           icache_rd, icache_waitrequest;
  logic                           dcache_rd, dcache_wr, dcache_waitrequest;
  logic [isa_pkg::xlen-1:0]       icache_data, dcache_data, dcache_wr_data, instr;
  logic                           instr_valid, instr_taken, redirect;
  logic [isa_pkg::reg_addr_w-1:0] rfile_rd_addr1, rfile_rd_addr2, rfile_wr_addr1, op_rd;
  logic [isa_pkg::xlen-1:0]       rfile_rd_data1, rfile_rd_data2, rfile_wr_data1;
  logic                           rfile_wr_enable1, op_valid, lsu_busy;
  logic [isa_pkg::kind_w-1:0]     op_kind;
  logic [isa_pkg::xlen-1:0]       op_value, op_store_data;

  fetch_unit fetch (.clock, .reset, .icache_addr, .icache_rd, .icache_data,
                    .icache_waitrequest, .instr_valid, .instr, .instr_pc,
                    .instr_taken, .redirect, .redirect_pc);

  execute_unit execute (.clock, .reset, .instr_valid, .instr, .instr_pc, .instr_taken,
                        .redirect, .redirect_pc, .rfile_rd_addr1, .rfile_rd_addr2,
                        .rfile_rd_data1, .rfile_rd_data2, .op_valid, .op_kind, .op_rd,
                        .op_value, .op_addr, .op_store_data, .op_pc, .lsu_busy);

  lsu lsu (.clock, .reset, .op_valid, .op_kind, .op_rd, .op_value, .op_addr,
           .op_store_data, .op_pc, .lsu_busy, .dcache_addr, .dcache_rd, .dcache_wr,
           .dcache_wr_data, .dcache_data, .dcache_waitrequest, .rfile_wr_addr1,
           .rfile_wr_enable1, .rfile_wr_data1, .retire_valid, .retire_pc, .retire_rd,
           .retire_data, .retire_wen);

  rfile regfile (.clock, .reset, .rd_addr1(rfile_rd_addr1), .rd_addr2(rfile_rd_addr2),
                 .wr_addr1(rfile_wr_addr1), .wr_enable1(rfile_wr_enable1),
                 .wr_data1(rfile_wr_data1), .rd_data1(rfile_rd_data1),
                 .rd_data2(rfile_rd_data2));

  tcm itcm (.clock, .reset, .cpu_addr(icache_addr), .cpu_rd(icache_rd), .cpu_wr(1'b0),
            .cpu_wr_data('0), .cpu_rd_data(icache_data),
            .cpu_waitrequest(icache_waitrequest), .load_en, .load_addr, .load_data);

  tcm dtcm (.clock, .reset, .cpu_addr(dcache_addr), .cpu_rd(dcache_rd),
            .cpu_wr(dcache_wr), .cpu_wr_data(dcache_wr_data), .cpu_rd_data(dcache_data),
            .cpu_waitrequest(dcache_waitrequest), .load_en(1'b0), .load_addr('0),
            .load_data('0));

endmodule

//--- sim/retire_checker.sv
`timescale 1ns/1ps

module retire_checker #(
  parameter int table_size = 32
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           retire_valid,
  input  logic [mem_pkg::addr_w-1:0]     retire_pc,
  input  logic [isa_pkg::reg_addr_w-1:0] retire_rd,
  input  logic [isa_pkg::xlen-1:0]       retire_data,
  input  logic                           retire_wen,
  input  int                             entry_count,
  input  logic [isa_pkg::reg_addr_w-1:0] exp_rd [table_size],
  input  logic [isa_pkg::xlen-1:0]       exp_data [table_size],
  input  logic                           exp_wen [table_size],
  input  logic                           exp_live [table_size],
  output logic                           checks_done,
  output int                             pass_count,
  output int                             error_count
);

  localparam int wait_limit = 200;

  task automatic wait_retire(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < wait_limit) begin
      @(negedge clock);  // Trace outputs are settled here
      cycles++;
      seen = retire_valid;
    end
  endtask

  task automatic compare_entry(input int idx);
    logic [mem_pkg::addr_w-1:0] pc;
    string                      msg;
    pc  = mem_pkg::reset_pc + idx * 4;  // Table row is also the word address
    msg = "";
    if (retire_pc !== pc)
      msg = {msg, $sformatf(" retire_pc got 0x%h exp 0x%h", retire_pc, pc)};
    if (retire_rd !== exp_rd[idx])
      msg = {msg, $sformatf(" retire_rd got 0x%h exp 0x%h", retire_rd, exp_rd[idx])};
    if (retire_wen !== exp_wen[idx])
      msg = {msg, $sformatf(" retire_wen got 0x%h exp 0x%h", retire_wen, exp_wen[idx])};
    // Data only counts when a register is written
    if (exp_wen[idx] && retire_data !== exp_data[idx])
      msg = {msg, $sformatf(" retire_data got 0x%h exp 0x%h", retire_data, exp_data[idx])};
    if (msg == "") begin
      pass_count++;
      $display("PASS entry %0d pc 0x%h rd %0d data 0x%h wen %0d",
               idx, retire_pc, retire_rd, retire_data, retire_wen);
    end else begin
      error_count++;
      $display("MISMATCH entry %0d:%s", idx, msg);
    end
  endtask

  initial begin
    int   idx;
    int   cycles;
    logic seen;
    checks_done = 1'b0;
    pass_count  = 0;
    error_count = 0;
    cycles      = 0;
    @(negedge clock);
    while (reset && cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (reset) begin
      $display("Reset was still high after %0d cycles, nothing was checked", wait_limit);
      error_count++;
    end else begin
      idx  = 0;
      seen = 1'b1;
      while (idx < entry_count && seen) begin
        if (!exp_live[idx]) begin
          $display("SKIP entry %0d pc 0x%h must not retire", idx, idx * 4);
        end else begin
          wait_retire(seen);
          if (seen) begin
            compare_entry(idx);
          end else begin
            $display("No instruction retired within %0d cycles for entry %0d",
                     wait_limit, idx);
            error_count++;
          end
        end
        idx++;
      end
    end
    checks_done = 1'b1;
  end

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int table_size = 32;
  localparam int run_limit  = 10000;

  logic                           clock;
  logic                           reset;
  logic                           load_en;
  logic [mem_pkg::index_w-1:0]    load_addr;
  logic [isa_pkg::xlen-1:0]       load_data;
  logic                           retire_valid;
  logic [mem_pkg::addr_w-1:0]     retire_pc;
  logic [isa_pkg::reg_addr_w-1:0] retire_rd;
  logic [isa_pkg::xlen-1:0]       retire_data;
  logic                           retire_wen;

  // Stimulus table, one row per program word
  logic [isa_pkg::xlen-1:0]       prog_word [table_size];
  logic [isa_pkg::reg_addr_w-1:0] exp_rd [table_size];
  logic [isa_pkg::xlen-1:0]       exp_data [table_size];
  logic                           exp_wen [table_size];
  logic                           exp_live [table_size];  // Low where a taken beq skips
  int                             entry_count;
  logic                           skip_next;
  logic [31:0]                    rand_state;
  logic                           checks_done;
  int                             pass_count;
  int                             error_count;

  core_top dut (.clock, .reset, .load_en, .load_addr, .load_data, .retire_valid,
                .retire_pc, .retire_rd, .retire_data, .retire_wen);

  retire_checker #(.table_size(table_size)) retire_check (
    .clock, .reset, .retire_valid, .retire_pc, .retire_rd, .retire_data, .retire_wen,
    .entry_count, .exp_rd, .exp_data, .exp_wen, .exp_live, .checks_done, .pass_count,
    .error_count);

  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] r;
    r = lcg_next();
    return r[27:16];  // Upper bits mix better
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // R, I and U words share the r_fmt field positions
  function automatic logic [31:0] r_word(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                         int rd, logic [6:0] opcode);
    isa_pkg::instr_t w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2[4:0];
    w.r_fmt.rs1    = rs1[4:0];
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd[4:0];
    w.r_fmt.opcode = opcode;
    return w;
  endfunction

  function automatic logic [31:0] i_word(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                         logic [6:0] opcode);
    return r_word(imm[11:5], int'(imm[4:0]), rs1, f3, rd, opcode);
  endfunction

  function automatic logic [31:0] u_word(logic [19:0] imm, int rd);
    return r_word(imm[19:13], int'(imm[12:8]), int'(imm[7:3]), imm[2:0], rd,
                  isa_pkg::op_lui);
  endfunction

  function automatic logic [31:0] s_word(logic [6:0] hi, int rs2, int rs1, logic [2:0] f3,
                                         logic [4:0] lo, logic [6:0] opcode);
    isa_pkg::instr_t w;
    w.s_fmt.imm_hi = hi;
    w.s_fmt.rs2    = rs2[4:0];
    w.s_fmt.rs1    = rs1[4:0];
    w.s_fmt.funct3 = f3;
    w.s_fmt.imm_lo = lo;
    w.s_fmt.opcode = opcode;
    return w;
  endfunction

  // Branch offset bits scattered over the store layout
  function automatic logic [31:0] b_word(logic [12:0] off, int rs2, int rs1);
    return s_word({off[12], off[10:5]}, rs2, rs1, isa_pkg::f3_beq, {off[4:1], off[11]},
                  isa_pkg::op_branch);
  endfunction

  task automatic add_entry(input logic [31:0] word, input int rd, input logic [31:0] data);
    prog_word[entry_count] = word;
    exp_rd[entry_count]    = rd[4:0];
    exp_data[entry_count]  = data;
    exp_wen[entry_count]   = (rd != 0);
    exp_live[entry_count]  = !skip_next;
    skip_next              = 1'b0;
    entry_count++;
  endtask

  task automatic build_table();
    logic [11:0] ia, ib, ic;
    logic [31:0] a, b, c, d;
    ia = rand_imm();
    ib = rand_imm();
    ic = rand_imm();
    a  = sext12(ia);
    b  = sext12(ib);
    c  = sext12(ic);
    d  = 32'd3 + c;
    add_entry(i_word(ia, 0, isa_pkg::f3_add, 1, isa_pkg::op_imm), 1, a);
    add_entry(i_word(ib, 0, isa_pkg::f3_add, 2, isa_pkg::op_imm), 2, b);
    add_entry(r_word(7'd0, 2, 1, isa_pkg::f3_add, 3, isa_pkg::op_reg), 3, a + b);
    add_entry(r_word(isa_pkg::f7_sub, 2, 1, isa_pkg::f3_add, 4, isa_pkg::op_reg), 4, a - b);
    add_entry(r_word(7'd0, 2, 1, isa_pkg::f3_and, 5, isa_pkg::op_reg), 5, a & b);
    add_entry(r_word(7'd0, 2, 1, isa_pkg::f3_or, 6, isa_pkg::op_reg), 6, a | b);
    add_entry(r_word(7'd0, 2, 1, isa_pkg::f3_xor, 7, isa_pkg::op_reg), 7, a ^ b);
    add_entry(u_word(20'hfffff, 8), 8, 32'hfffff000);
    add_entry(i_word(12'd5, 0, isa_pkg::f3_add, 9, isa_pkg::op_imm), 9, 32'd5);
    add_entry(r_word(7'd0, 9, 8, isa_pkg::f3_slt, 10, isa_pkg::op_reg), 10, 32'd1);
    add_entry(r_word(7'd0, 8, 9, isa_pkg::f3_slt, 11, isa_pkg::op_reg), 11, 32'd0);
    add_entry(i_word(12'd7, 9, isa_pkg::f3_add, 0, isa_pkg::op_imm), 0, 32'd12);  // x0 kept
    add_entry(r_word(7'd0, 9, 0, isa_pkg::f3_add, 12, isa_pkg::op_reg), 12, 32'd5);
    add_entry(u_word(20'h12345, 13), 13, 32'h12345000);
    add_entry(i_word(12'h678, 13, isa_pkg::f3_add, 13, isa_pkg::op_imm), 13, 32'h12345678);
    add_entry(i_word(12'd64, 0, isa_pkg::f3_add, 14, isa_pkg::op_imm), 14, 32'd64);
    add_entry(s_word(7'd0, 13, 14, 3'b010, 5'd4, isa_pkg::op_store), 0, 32'h0);
    add_entry(i_word(12'd4, 14, 3'b010, 15, isa_pkg::op_load), 15, 32'h12345678);
    add_entry(i_word(12'hfff, 15, isa_pkg::f3_add, 15, isa_pkg::op_imm), 15, 32'h12345677);
    add_entry(b_word(13'd8, 12, 9), 0, 32'h0);  // x9 equals x12, taken
    skip_next = 1'b1;
    add_entry(i_word(12'd99, 0, isa_pkg::f3_add, 16, isa_pkg::op_imm), 16, 32'd99);
    add_entry(i_word(12'd3, 0, isa_pkg::f3_add, 17, isa_pkg::op_imm), 17, 32'd3);
    add_entry(b_word(13'd8, 9, 17), 0, 32'h0);  // 3 against 5, falls through
    add_entry(i_word(ic, 17, isa_pkg::f3_add, 18, isa_pkg::op_imm), 18, d);
    add_entry(r_word(7'd0, 17, 18, isa_pkg::f3_slt, 19, isa_pkg::op_reg), 19,
              ($signed(d) < $signed(32'd3)) ? 32'd1 : 32'd0);
    add_entry(b_word(13'd0, 0, 0), 0, 32'h0);  // Parks the core on itself
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    int cycles;
    reset       = 1'b1;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    rand_state  = 32'h3bbb;
    skip_next   = 1'b0;
    entry_count = 0;
    build_table();
    for (int i = 0; i < entry_count; i++) begin
      @(negedge clock);
      load_en   = 1'b1;
      load_addr = i[mem_pkg::index_w-1:0];
      load_data = prog_word[i];
    end
    @(negedge clock);
    load_en = 1'b0;
    repeat (3) @(negedge clock);  // Reset stays up 3 more cycles past the load
    reset  = 1'b0;
    cycles = 0;
    while (!checks_done && cycles < run_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!checks_done)
      $display("Timeout: the checker did not finish within %0d cycles", run_limit);
    $display("Summary: %0d passed, %0d errors", pass_count, error_count);
    if (checks_done && error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/tcm.sv
rtl/fetch_unit.sv
rtl/rfile.sv
rtl/execute_unit.sv
rtl/lsu.sv
rtl/core_top.sv
sim/retire_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the Verilator model of tb_top and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f compile.f --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_top_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
